//--- include/agen_settings.svh
// address unit sizing: address width, page and cache line offsets, page-map depth
`ifndef AGEN_SETTINGS_SVH
`define AGEN_SETTINGS_SVH

// ====================
// address space
// ====================

// virtual and physical addresses share one width
`define AGEN_ADDR_W 32

// 4 KiB pages, so the page number is the upper 20 bits
`define AGEN_PAGE_BITS 12

// ====================
// cache and translation
// ====================

// 64-byte lines, used by next-line rounding
`define AGEN_LINE_BITS 6

// entries in the software-loaded page map
`define AGEN_MAP_ENTRIES 4

`endif

//--- verilog/agen_pkg.sv
// address unit types: opcodes, instruction formats and union, operation and result structs, faults
`default_nettype none

package agen_pkg;

`include "agen_settings.svh"

	// ====================
	// basic widths
	// ====================

	// virtual or physical byte address
	typedef logic [`AGEN_ADDR_W-1:0] address_t;

	// page numbers, everything above the page offset
	typedef logic [`AGEN_ADDR_W-`AGEN_PAGE_BITS-1:0] vpn_t;
	typedef logic [`AGEN_ADDR_W-`AGEN_PAGE_BITS-1:0] ppn_t;

	// access size as log2 of bytes: 0 byte, 1 wyde, 2 tetra, 3 octa
	typedef logic [1:0] size_t;

	// ====================
	// opcodes
	// ====================

	// low two bits pick load, unsigned load or store within a size group
	typedef enum logic [6:0] {
		LDB  = 7'h10,
		LDBU = 7'h11,
		STB  = 7'h12,
		LDW  = 7'h14,
		LDWU = 7'h15,
		STW  = 7'h16,
		LDT  = 7'h18,
		LDTU = 7'h19,
		STT  = 7'h1A,
		LDO  = 7'h1C,
		STO  = 7'h1E,
		AMO  = 7'h2F
	} opcode_t;

	// ====================
	// instruction word
	// ====================

	// load/store view: disp is a signed byte
	typedef struct packed {
		opcode_t    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [1:0] sc;
		logic [7:0] disp;
	} lsn_fmt_t;

	// atomic view: same opcode and register fields, size carried in the word
	typedef struct packed {
		opcode_t    opcode;
		logic [4:0] rt;
		logic [4:0] ra;
		logic [4:0] rb;
		logic [3:0] amo_fn;
		logic [2:0] amo_size;
		logic [2:0] spare;
	} amo_fmt_t;

	// one 32-bit word read either way
	typedef union packed {
		lsn_fmt_t lsn;
		amo_fmt_t amo;
	} insn_t;

	// ====================
	// pipeline payloads
	// ====================

	// priority order is illegal, misalign, miss
	typedef enum logic [1:0] {
		FLT_NONE,
		FLT_ILLEGAL,
		FLT_MISALIGN,
		FLT_MISS
	} fault_t;

	// decoded memory op as handed to agen
	typedef struct packed {
		logic     is_amo;
		logic     illegal;
		size_t    size;
		logic [1:0] sc;
		address_t disp;
		address_t a;
		address_t b;
		logic     next_line;
	} mem_op_t;

	// translated address with its fault code
	typedef struct packed {
		address_t paddr;
		fault_t   fault;
		size_t    size;
	} xlate_result_t;

endpackage

`default_nettype wire

//--- verilog/mem_op_decode.sv
// memory op decoder: reads the instruction union and registers the decoded operation
`default_nettype none
`timescale 1ns/100ps

module mem_op_decode (
	input  wire logic               clk,
	input  wire logic               rst,
	input  wire logic               in_valid,
	input  wire agen_pkg::insn_t    insn,
	input  wire agen_pkg::address_t a,
	input  wire agen_pkg::address_t b,
	input  wire logic               next_line,
	output agen_pkg::mem_op_t       op,
	output logic                    op_valid
);

	import agen_pkg::*;

	// decoded op before the register
	mem_op_t op_d;

	// ====================
	// decode
	// ====================

	always_comb begin
		op_d = '0;
		// operands pass straight through
		op_d.a = a;
		op_d.b = b;
		op_d.next_line = next_line;
		// load/store view supplies the scale and displacement
		op_d.sc = insn.lsn.sc;
		op_d.disp = address_t'($signed(insn.lsn.disp));
		// opcode sits in the same bits in both formats
		case (insn.lsn.opcode)
			LDB, LDBU, STB:
				op_d.size = 2'd0;
			LDW, LDWU, STW:
				op_d.size = 2'd1;
			LDT, LDTU, STT:
				op_d.size = 2'd2;
			LDO, STO:
				op_d.size = 2'd3;
			AMO: begin
				op_d.is_amo = 1'b1;
				// atomics use an unscaled index and no displacement
				op_d.sc = 2'd0;
				op_d.disp = '0;
				// size comes from the atomic view of the word
				op_d.size = insn.amo.amo_size[1:0];
				// nothing wider than an octa
				op_d.illegal = insn.amo.amo_size > 3'd3;
			end
			default:
				op_d.illegal = 1'b1;
		endcase
	end

	// ====================
	// op register
	// ====================

	always_ff @(posedge clk) begin
		if (rst) begin
			op_valid <= 1'b0;
		end else begin
			op_valid <= in_valid;
		end
		// op is held until the next issue, agen and the translator read it later
		if (in_valid) begin
			op <= op_d;
		end
	end

	// one op is in flight at a time, the pipe needs four cycles to drain
	a_issue_spacing: assert property (@(posedge clk) disable iff (rst)
		in_valid |=> !in_valid [*3]);

endmodule

`default_nettype wire

//--- verilog/agen.sv
// address generator: effective address adder, next-line rounding, sticky result valid
`default_nettype none
`timescale 1ns/100ps

`include "agen_settings.svh"

module agen (
	input  wire logic              clk,
	input  wire logic              rst,
	input  wire agen_pkg::mem_op_t op,
	input  wire logic              op_valid,
	input  wire logic              done,
	output agen_pkg::address_t     vaddr,
	output logic                   vaddr_valid
);

	import agen_pkg::*;

	localparam int LINE_BITS = `AGEN_LINE_BITS;

	address_t scaled_b;
	address_t sum;
	address_t vaddr_d;
	// first stage of the sticky valid
	logic     valid_s1;

	// ====================
	// adder
	// ====================

	always_comb begin
		scaled_b = op.b << op.sc;
		// atomics add the raw index only
		if (op.is_amo) begin
			sum = op.a + op.b;
		end else begin
			sum = op.a + scaled_b + op.disp;
		end
		// next line: drop the line offset and step the line number
		if (op.next_line) begin
			vaddr_d = {sum[`AGEN_ADDR_W-1:LINE_BITS] + 1'b1, {LINE_BITS{1'b0}}};
		end else begin
			vaddr_d = sum;
		end
	end

	// address loads with the op strobe and then holds for the translator
	always_ff @(posedge clk) begin
		if (op_valid) begin
			vaddr <= vaddr_d;
		end
	end

	// ====================
	// sticky valid
	// ====================

	// set by the op strobe, handed on a cycle later,
	// both stages drop as soon as the translator reports done
	always_ff @(posedge clk) begin
		if (rst) begin
			valid_s1 <= 1'b0;
			vaddr_valid <= 1'b0;
		end else begin
			if (op_valid) begin
				valid_s1 <= 1'b1;
			end
			vaddr_valid <= valid_s1;
			if (done) begin
				valid_s1 <= 1'b0;
				vaddr_valid <= 1'b0;
			end
		end
	end

	// the translator only finishes an address that is still held here
	a_done_needs_valid: assert property (@(posedge clk) disable iff (rst)
		done |-> vaddr_valid);

endmodule

`default_nettype wire

//--- verilog/addr_xlate.sv
// address translator: page map, parallel lookup, alignment check, fault priority, done strobe
`default_nettype none
`timescale 1ns/100ps

`include "agen_settings.svh"

module addr_xlate (
	input  wire logic                                  clk,
	input  wire logic                                  rst,
	input  wire agen_pkg::address_t                    vaddr,
	input  wire logic                                  vaddr_valid,
	input  wire agen_pkg::size_t                       size,
	input  wire logic                                  illegal,
	input  wire logic                                  map_we,
	input  wire logic [$clog2(`AGEN_MAP_ENTRIES)-1:0]  map_idx,
	input  wire agen_pkg::vpn_t                        map_vpn,
	input  wire agen_pkg::ppn_t                        map_ppn,
	output logic                                       out_valid,
	output agen_pkg::xlate_result_t                    result
);

	import agen_pkg::*;

	localparam int ENTRIES = `AGEN_MAP_ENTRIES;
	localparam int PAGE_BITS = `AGEN_PAGE_BITS;

	// ====================
	// page map
	// ====================

	vpn_t               entry_vpn [ENTRIES];
	ppn_t               entry_ppn [ENTRIES];
	logic [ENTRIES-1:0] entry_v;

	// a write is visible to a lookup on the next edge
	always_ff @(posedge clk) begin
		if (rst) begin
			entry_v <= '0;
		end else if (map_we) begin
			entry_v[map_idx] <= 1'b1;
		end
		if (map_we) begin
			entry_vpn[map_idx] <= map_vpn;
			entry_ppn[map_idx] <= map_ppn;
		end
	end

	// ====================
	// lookup and checks
	// ====================

	vpn_t               va_vpn;
	logic [ENTRIES-1:0] hit_vec;
	ppn_t               hit_ppn;
	logic               hit;
	logic [2:0]         low_mask;
	logic               misalign;
	logic               fire;
	xlate_result_t      res_d;

	always_comb begin
		va_vpn = vaddr[`AGEN_ADDR_W-1:PAGE_BITS];
		hit_ppn = '0;
		// all entries compare at once, at most one may match
		for (int i = 0; i < ENTRIES; i++) begin
			hit_vec[i] = entry_v[i] && (entry_vpn[i] == va_vpn);
			if (hit_vec[i]) begin
				hit_ppn = hit_ppn | entry_ppn[i];
			end
		end
		hit = |hit_vec;
		// low bits that must be zero for this size
		low_mask = 3'((4'd1 << size) - 4'd1);
		misalign = |(vaddr[2:0] & low_mask);
	end

	// fault priority: illegal, then misalign, then miss
	always_comb begin
		res_d.size = size;
		res_d.paddr = hit ? {hit_ppn, vaddr[PAGE_BITS-1:0]} : '0;
		if (illegal) begin
			res_d.fault = FLT_ILLEGAL;
			res_d.paddr = '0;
		end else if (misalign) begin
			// keeps the translated address when the page hits
			res_d.fault = FLT_MISALIGN;
		end else if (!hit) begin
			res_d.fault = FLT_MISS;
		end else begin
			res_d.fault = FLT_NONE;
		end
	end

	// ====================
	// result register
	// ====================

	// agen's valid stays up one cycle past the strobe, a pending result blocks a repeat
	assign fire = vaddr_valid && !out_valid;

	always_ff @(posedge clk) begin
		if (rst) begin
			out_valid <= 1'b0;
		end else begin
			out_valid <= fire;
		end
		if (fire) begin
			result <= res_d;
		end
	end

	// software must never load two live entries for one page
	a_unique_hit: assert property (@(posedge clk) disable iff (rst)
		vaddr_valid |-> $onehot0(hit_vec));

endmodule

`default_nettype wire

//--- verilog/agen_unit.sv
// address unit top level: decoder, address generator and translator
`default_nettype none
`timescale 1ns/100ps

`include "agen_settings.svh"

module agen_unit (
	input  wire logic                                  clk,
	input  wire logic                                  rst,
	// issue side
	input  wire logic                                  in_valid,
	input  wire agen_pkg::insn_t                       insn,
	input  wire agen_pkg::address_t                    a,
	input  wire agen_pkg::address_t                    b,
	input  wire logic                                  next_line,
	// page-map load
	input  wire logic                                  map_we,
	input  wire logic [$clog2(`AGEN_MAP_ENTRIES)-1:0]  map_idx,
	input  wire agen_pkg::vpn_t                        map_vpn,
	input  wire agen_pkg::ppn_t                        map_ppn,
	// translated result
	output logic                                       out_valid,
	output agen_pkg::xlate_result_t                    result
);

	import agen_pkg::*;

	// decoder to agen
	mem_op_t  op;
	logic     op_valid;
	// agen to translator
	address_t vaddr;
	logic     vaddr_valid;

	mem_op_decode decode_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.insn      (insn),
		.a         (a),
		.b         (b),
		.next_line (next_line),
		.op        (op),
		.op_valid  (op_valid)
	);

	// out_valid doubles as the done strobe
	agen agen_i (
		.clk         (clk),
		.rst         (rst),
		.op          (op),
		.op_valid    (op_valid),
		.done        (out_valid),
		.vaddr       (vaddr),
		.vaddr_valid (vaddr_valid)
	);

	// size and illegal come from the held op
	addr_xlate xlate_i (
		.clk         (clk),
		.rst         (rst),
		.vaddr       (vaddr),
		.vaddr_valid (vaddr_valid),
		.size        (op.size),
		.illegal     (op.illegal),
		.map_we      (map_we),
		.map_idx     (map_idx),
		.map_vpn     (map_vpn),
		.map_ppn     (map_ppn),
		.out_valid   (out_valid),
		.result      (result)
	);

endmodule

`default_nettype wire

//--- test/agen_unit_tb.sv
// agen_unit testbench: clock, reset, pattern reader, stimulus, compare tasks, watchdog, report
`default_nettype none
`timescale 1ns/100ps

`include "agen_settings.svh"

module agen_unit_tb;

	import agen_pkg::*;

	localparam int IDX_W = $clog2(`AGEN_MAP_ENTRIES);
	localparam int VPN_W = `AGEN_ADDR_W - `AGEN_PAGE_BITS;
	localparam int NAME_W = 8 * 24;
	// falling edges from the issue strobe to out_valid
	localparam int LATENCY = 4;

	// one pattern file line holds a map write or an operation
	typedef struct packed {
		logic              is_op;
		logic [NAME_W-1:0] name;
		insn_t             insn;
		address_t          a;
		address_t          b;
		logic              next_line;
		address_t          exp_paddr;
		fault_t            exp_fault;
		logic [IDX_W-1:0]  map_idx;
		vpn_t              map_vpn;
		ppn_t              map_ppn;
	} pattern_t;

	logic          clk;
	logic          rst;
	logic          in_valid;
	insn_t         insn;
	address_t      a;
	address_t      b;
	logic          next_line;
	logic          map_we;
	logic [IDX_W-1:0] map_idx;
	vpn_t          map_vpn;
	ppn_t          map_ppn;
	logic          out_valid;
	xlate_result_t result;

	pattern_t patterns[$];
	int       error_count;
	int       tests_passed;
	int       tests_failed;
	int       cycle_count;
	int       cycle_limit;

	agen_unit dut_i (
		.clk       (clk),
		.rst       (rst),
		.in_valid  (in_valid),
		.insn      (insn),
		.a         (a),
		.b         (b),
		.next_line (next_line),
		.map_we    (map_we),
		.map_idx   (map_idx),
		.map_vpn   (map_vpn),
		.map_ppn   (map_ppn),
		.out_valid (out_valid),
		.result    (result)
	);

	// 4 ns period
	always #2 clk = ~clk;

	// watchdog whose limit is set once the patterns are known
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("timeout: out_valid never came, run stopped after %0d cycles", cycle_count);
			$display("TEST FAILED");
			$finish;
		end
	end

	// ====================
	// compare tasks
	// ====================

	task automatic check_addr(input logic [NAME_W-1:0] name, input address_t expected,
		input address_t actual);
		if (actual !== expected) begin
			$display("error %s paddr: expected %h, actual %h", name, expected, actual);
			error_count++;
		end
	endtask

	task automatic check_fault(input logic [NAME_W-1:0] name, input fault_t expected,
		input fault_t actual);
		if (actual !== expected) begin
			$display("error %s fault: expected %s, actual %s", name, expected.name(),
				actual.name());
			error_count++;
		end
	endtask

	task automatic check_size(input logic [NAME_W-1:0] name, input size_t expected,
		input size_t actual);
		if (actual !== expected) begin
			$display("error %s size: expected %0d, actual %0d", name, expected, actual);
			error_count++;
		end
	endtask

	// access size by opcode group, atomics carry their own size field
	function automatic size_t expected_size(input insn_t word);
		size_t sz;
		sz = 2'd0;
		if (word.amo.opcode == AMO) begin
			sz = size_t'(word.amo.amo_size);
		end else if (word.lsn.opcode inside {LDW, LDWU, STW}) begin
			sz = 2'd1;
		end else if (word.lsn.opcode inside {LDT, LDTU, STT}) begin
			sz = 2'd2;
		end else if (word.lsn.opcode inside {LDO, STO}) begin
			sz = 2'd3;
		end
		return sz;
	endfunction

	// ====================
	// pattern file
	// ====================

	task automatic load_patterns();
		int                fd;
		int                code;
		logic              reading;
		logic [63:0]       kind;
		logic [NAME_W-1:0] name;
		logic [31:0]       v0;
		logic [31:0]       v1;
		logic [31:0]       v2;
		logic [31:0]       v3;
		logic [31:0]       v4;
		logic [31:0]       v5;
		logic [8*160-1:0]  rest;
		pattern_t          p;
		fd = $fopen("test/agen_unit_patterns.txt", "r");
		reading = (fd != 0);
		if (fd == 0) begin
			$display("could not open the pattern file test/agen_unit_patterns.txt");
			error_count++;
		end
		while (reading) begin
			kind = '0;
			name = '0;
			p = '0;
			code = $fscanf(fd, "%s", kind);
			if (code != 1) begin
				reading = 1'b0;
			end else if (kind == 64'("#")) begin
				// rest of a comment line
				code = $fgets(rest, fd);
			end else if (kind == 64'("map")) begin
				code = $fscanf(fd, "%h %h %h", v0, v1, v2);
				p.map_idx = v0[IDX_W-1:0];
				p.map_vpn = v1[VPN_W-1:0];
				p.map_ppn = v2[VPN_W-1:0];
				if (code == 3) begin
					patterns.push_back(p);
				end else begin
					$display("pattern file has a map line with missing fields");
					error_count++;
				end
			end else if (kind == 64'("op")) begin
				code = $fscanf(fd, "%s %h %h %h %h %h %h", name, v0, v1, v2, v3, v4, v5);
				p.is_op = 1'b1;
				p.name = name;
				p.insn = v0;
				p.a = v1;
				p.b = v2;
				p.next_line = v3[0];
				p.exp_paddr = v4;
				p.exp_fault = fault_t'(v5[1:0]);
				if (code == 7) begin
					patterns.push_back(p);
				end else begin
					$display("pattern file has an op line with missing fields");
					error_count++;
				end
			end else begin
				$display("pattern file has a line of unknown kind %s", kind);
				error_count++;
			end
		end
		if (fd != 0) begin
			$fclose(fd);
		end
	endtask

	// ====================
	// stimulus
	// ====================

	task automatic write_map(input pattern_t p);
		map_we = 1'b1;
		map_idx = p.map_idx;
		map_vpn = p.map_vpn;
		map_ppn = p.map_ppn;
		@(negedge clk);
		map_we = 1'b0;
	endtask

	// issue one op, wait for its result, then idle two cycles
	task automatic run_op(input pattern_t p);
		int lat;
		int errors_before;
		errors_before = error_count;
		in_valid = 1'b1;
		insn = p.insn;
		a = p.a;
		b = p.b;
		next_line = p.next_line;
		@(negedge clk);
		in_valid = 1'b0;
		lat = 1;
		while (!out_valid) begin
			@(negedge clk);
			lat++;
		end
		if (lat != LATENCY) begin
			$display("%s: out_valid came %0d cycles after issue instead of %0d", p.name, lat,
				LATENCY);
			error_count++;
		end
		check_addr(p.name, p.exp_paddr, result.paddr);
		check_fault(p.name, p.exp_fault, result.fault);
		// an illegal op has no defined size
		if (p.exp_fault != FLT_ILLEGAL) begin
			check_size(p.name, expected_size(p.insn), result.size);
		end
		// a second pulse for the same op is a failure
		repeat (2) begin
			@(negedge clk);
			if (out_valid) begin
				$display("%s: out_valid pulsed more than once for one op", p.name);
				error_count++;
			end
		end
		if (error_count == errors_before) begin
			$display("pass %s", p.name);
			tests_passed++;
		end else begin
			$display("fail %s", p.name);
			tests_failed++;
		end
	endtask

	// ====================
	// main sequence
	// ====================

	initial begin
		clk = 1'b0;
		rst = 1'b1;
		in_valid = 1'b0;
		insn = '0;
		a = '0;
		b = '0;
		next_line = 1'b0;
		map_we = 1'b0;
		map_idx = '0;
		map_vpn = '0;
		map_ppn = '0;
		error_count = 0;
		tests_passed = 0;
		tests_failed = 0;
		cycle_count = 0;
		cycle_limit = 1000000;
		load_patterns();
		// reset, eight cycles per pattern line, and slack
		cycle_limit = 8 + 8 * patterns.size() + 50;
		repeat (8) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		foreach (patterns[i]) begin
			if (patterns[i].is_op) begin
				run_op(patterns[i]);
			end else begin
				write_map(patterns[i]);
			end
		end
		@(negedge clk);
		$display("%0d tests passed, %0d tests failed", tests_passed, tests_failed);
		if (error_count == 0 && tests_failed == 0 && tests_passed > 0) begin
			$display("TEST OK");
		end else begin
			$display("TEST FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- agen_unit.f
+incdir+include
verilog/agen_pkg.sv
verilog/mem_op_decode.sv
verilog/agen.sv
verilog/addr_xlate.sv
verilog/agen_unit.sv
test/agen_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
# build the agen_unit testbench with Verilator, run it and scan the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f agen_unit.f \
	--top-module agen_unit_tb \
	-o agen_unit_sim

status=0
./obj_dir/agen_unit_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -q "TEST FAILED" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"

//--- test/agen_unit_patterns.txt
# map lines:  map <idx> <vpn> <ppn>, all hex
# op lines:   op <name> <insn> <a> <b> <next_line> <exp_paddr> <exp_fault>, all hex
map 0 00010 80000
map 1 00011 80123
map 2 00020 9abcd
# load and store, every scale, both displacement signs
op ldb_sc0_pos 20000005 00010100 00000020 0 80000125 0
op ldw_sc1_neg 280001fc 00010200 00000010 0 8000021c 0
op stt_sc2_pos 34000210 00011000 00000003 0 8012301c 0
op sto_sc3_neg 3c000380 00020400 00000005 0 9abcd3a8 0
op ldtu_sc2_neg 320002f8 00010800 00000002 0 80000800 0
op ldbu_disp_back 220000ff 00011000 00000000 0 80000fff 0
# atomics with nonzero bits where the load/store view keeps sc and disp
op amo_octa 5e000158 00011100 00000040 0 80123140 0
op amo_wyde 5e0003cf 00020000 00000102 0 9abcd102 0
# next-line rounding
op nl_mid_line 20000001 00010040 00000003 1 80000080 0
op nl_on_boundary 38000000 00010100 00000000 1 80000140 0
op nl_page_carry 2c000000 00010fc8 00000004 1 80123000 0
# faults
op bad_opcode 26000000 00010000 00000000 0 00000000 1
op amo_size_4 5e000020 00010000 00000008 0 00000000 1
op misalign_wyde 28000001 00010010 00000000 0 80000011 2
op misalign_miss 30000002 00050000 00000000 0 00000000 2
op page_miss 20000000 00030000 00000010 0 00000000 3
op illegal_over_miss fe000000 00030000 00000000 0 00000000 1
# map rewrite and a fresh entry
map 2 00020 55555
op remap_hit 20000000 00020000 00000123 0 55555123 0
map 3 00030 00abc
op new_entry_hit 20000000 00030000 00000010 0 00abc010 0
